/* design/eth_tx_pkg.sv */
package eth_tx_pkg;

	// ==============================
	// widths with a meaning
	// ==============================
	typedef logic [7:0]  byte_t;     // one frame byte
	typedef logic [47:0] mac_t;
	typedef logic [23:0] interval_t; // cycles between burst starts
	typedef logic [15:0] gap_t;      // cycles between copies
	typedef logic [2:0]  copies_t;   // 0 behaves as 1
	typedef logic [6:0]  plen_t;     // payload length 1..64
	typedef logic [5:0]  paddr_t;    // payload ram address

	typedef enum logic [1:0] {spd_1000, spd_100, spd_10} speed_t;

	// ==============================
	// frame format
	// ==============================
	localparam logic [15:0] ethertype = 16'h88B5;
	localparam byte_t preamble_byte = 8'h55;
	localparam byte_t sfd_byte      = 8'hD5;
	localparam int min_frame_bytes = 60; // before fcs
	localparam int header_bytes    = 16; // macs, type, copy, seq
	localparam int payload_max     = 64;
	localparam logic [31:0] crc_poly_refl = 32'hEDB88320; // 0x04c11db7 bit reversed
	localparam int tail_strobes = 16; // crc + preamble pipeline drain

	// ==============================
	// axi4-lite register map
	// ==============================
	localparam int axi_addr_w = 8;
	localparam int axi_data_w = 32;
	localparam logic [1:0] axi_okay = 2'b00;

	localparam logic [axi_addr_w-1:0] reg_ctrl     = 8'h00; // bit0 enable, bits 2:1 speed
	localparam logic [axi_addr_w-1:0] reg_interval = 8'h04;
	localparam logic [axi_addr_w-1:0] reg_copies   = 8'h08;
	localparam logic [axi_addr_w-1:0] reg_gap      = 8'h0C;
	localparam logic [axi_addr_w-1:0] reg_length   = 8'h10;
	localparam logic [axi_addr_w-1:0] reg_dst_lo   = 8'h14;
	localparam logic [axi_addr_w-1:0] reg_dst_hi   = 8'h18;
	localparam logic [axi_addr_w-1:0] reg_src_lo   = 8'h1C;
	localparam logic [axi_addr_w-1:0] reg_src_hi   = 8'h20;
	localparam logic [axi_addr_w-1:0] reg_status   = 8'h24; // frames sent, read only
	localparam logic [1:0] pl_window = 2'b01; // addr[7:6] of 0x40..0x7f

	// fsm states
	typedef enum logic [1:0] {b_idle, b_header, b_payload, b_pad} build_state_t;
	typedef enum logic [1:0] {s_idle, s_wait_gap, s_wait_busy} sched_state_t;

endpackage

/* design/tx_cfg_if.sv */
`timescale 1ns/10ps

interface tx_cfg_if;
	import eth_tx_pkg::*;

	logic      enable;
	speed_t    speed;
	interval_t interval;
	copies_t   copies;
	gap_t      gap;
	plen_t     length;
	mac_t      dst_mac;
	mac_t      src_mac;

	// register block owns every field
	modport csr (output enable, speed, interval, copies, gap, length, dst_mac, src_mac);
	modport sched (input enable, speed, interval, copies, gap);
	modport builder (input length, dst_mac, src_mac);

endinterface

/* design/tx_csr_axil.sv */
`timescale 1ns/10ps

module tx_csr_axil (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic [eth_tx_pkg::axi_addr_w-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [eth_tx_pkg::axi_data_w-1:0] wdata,
	input  logic [eth_tx_pkg::axi_data_w/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic [eth_tx_pkg::axi_addr_w-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic rvalid,
	input  logic rready,
	output logic [eth_tx_pkg::axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	input  logic frame_done,
	output logic pl_we,
	output eth_tx_pkg::paddr_t pl_addr,
	output eth_tx_pkg::byte_t pl_data,
	tx_cfg_if.csr cfg
);
	import eth_tx_pkg::*;

	logic [axi_data_w-1:0] frame_cnt;
	logic [axi_data_w-1:0] wr_word; // old value merged with strobed lanes

	// readback of one register, zero when unmapped
	function automatic logic [axi_data_w-1:0] rd_word(input logic [axi_addr_w-1:0] addr);
		case (addr)
			reg_ctrl:     rd_word = {29'd0, cfg.speed, cfg.enable};
			reg_interval: rd_word = {8'd0, cfg.interval};
			reg_copies:   rd_word = {29'd0, cfg.copies};
			reg_gap:      rd_word = {16'd0, cfg.gap};
			reg_length:   rd_word = {25'd0, cfg.length};
			reg_dst_lo:   rd_word = cfg.dst_mac[31:0];
			reg_dst_hi:   rd_word = {16'd0, cfg.dst_mac[47:32]};
			reg_src_lo:   rd_word = cfg.src_mac[31:0];
			reg_src_hi:   rd_word = {16'd0, cfg.src_mac[47:32]};
			reg_status:   rd_word = frame_cnt;
			default:      rd_word = '0;
		endcase
	endfunction

	always_comb begin
		wr_word = rd_word(awaddr);
		for (int i = 0; i < axi_data_w/8; i++) begin
			if (wstrb[i]) wr_word[8*i +: 8] = wdata[8*i +: 8];
		end
	end

	assign bresp = axi_okay; // never an error
	assign rresp = axi_okay;

	// ==============================
	// write channel
	// ==============================
	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			// aw and w taken together, one write in flight
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0; // held until master takes it
		end
	end

	// config fields, updated in the handshake cycle
	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			cfg.enable   <= 1'b0;
			cfg.speed    <= spd_1000;
			cfg.interval <= '0;
			cfg.copies   <= '0;
			cfg.gap      <= '0;
			cfg.length   <= '0;
			cfg.dst_mac  <= '0;
			cfg.src_mac  <= '0;
			frame_cnt    <= '0;
			pl_we        <= 1'b0;
		end else begin
			pl_we <= awready && wstrb[0] && (awaddr[7:6] == pl_window);
			if (frame_done) frame_cnt <= frame_cnt + 1'b1;
			if (awready) begin
				case (awaddr)
					reg_ctrl: begin
						cfg.enable <= wr_word[0];
						cfg.speed  <= speed_t'(wr_word[2:1]);
					end
					reg_interval: cfg.interval <= wr_word[23:0];
					reg_copies:   cfg.copies   <= wr_word[2:0];
					reg_gap:      cfg.gap      <= wr_word[15:0];
					reg_length:   cfg.length   <= wr_word[6:0];
					reg_dst_lo:   cfg.dst_mac[31:0]  <= wr_word;
					reg_dst_hi:   cfg.dst_mac[47:32] <= wr_word[15:0];
					reg_src_lo:   cfg.src_mac[31:0]  <= wr_word;
					reg_src_hi:   cfg.src_mac[47:32] <= wr_word[15:0];
					default: ; // status and payload window
				endcase
			end
		end
	end

	// payload window, one ram entry per byte address
	always_ff @(posedge clk125MHz) begin
		if (awready) begin
			pl_addr <= awaddr[5:0];
			pl_data <= wdata[7:0]; // low byte only
		end
	end

	// ==============================
	// read channel
	// ==============================
	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (arready) rdata <= rd_word(araddr); // araddr still valid here
	end

endmodule

/* design/tx_scheduler.sv */
`timescale 1ns/10ps

module tx_scheduler (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic busy,
	output logic start,
	output eth_tx_pkg::copies_t copy_idx,
	output eth_tx_pkg::byte_t seq,
	output logic adv,
	tx_cfg_if.sched cfg
);
	import eth_tx_pkg::*;

	logic [6:0] div_cnt;
	logic [6:0] div_max;
	interval_t ivl_cnt;
	logic expire;
	gap_t gap_cnt;
	gap_t gap_q;       // sampled at burst start
	copies_t copies_q;
	sched_state_t state;

	// strobe divider per link speed
	always_comb begin
		case (cfg.speed)
			spd_100: div_max = 7'd9;  // every 10th cycle
			spd_10:  div_max = 7'd99; // every 100th
			default: div_max = 7'd0;  // gigabit, every cycle
		endcase
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			div_cnt <= '0;
			adv     <= 1'b0;
		end else begin
			adv     <= (div_cnt == 7'd0);
			div_cnt <= (div_cnt >= div_max) ? 7'd0 : div_cnt + 7'd1;
		end
	end

	// burst interval timer, reloads on expiry
	assign expire = cfg.enable && (ivl_cnt >= cfg.interval);

	always_ff @(posedge clk125MHz) begin
		if (!rst_n || !cfg.enable || expire)
			ivl_cnt <= '0;
		else
			ivl_cnt <= ivl_cnt + 1'b1;
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			state    <= s_idle;
			start    <= 1'b0;
			copy_idx <= '0;
			seq      <= '0;
			gap_cnt  <= '0;
			gap_q    <= '0;
			copies_q <= '0;
		end else begin
			start <= 1'b0; // single cycle pulse
			case (state)
				s_idle: if (expire && !busy) begin
					copies_q <= (cfg.copies == '0) ? copies_t'(1) : cfg.copies;
					gap_q    <= cfg.gap;
					copy_idx <= copies_t'(1);
					seq      <= seq + 1'b1; // once per burst
					start    <= 1'b1;
					state    <= s_wait_busy;
				end
				s_wait_busy: if (!busy) begin
					gap_cnt <= '0;
					state   <= (copy_idx >= copies_q) ? s_idle : s_wait_gap;
				end
				s_wait_gap: begin
					if (!cfg.enable)
						state <= s_idle; // drop rest of burst
					else if (gap_cnt >= gap_q && !busy) begin
						start    <= 1'b1;
						copy_idx <= copy_idx + 1'b1;
						state    <= s_wait_busy;
					end else
						gap_cnt <= gap_cnt + 1'b1;
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

/* design/frame_builder.sv */
`timescale 1ns/10ps

module frame_builder (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic start,
	input  eth_tx_pkg::copies_t copy_idx,
	input  eth_tx_pkg::byte_t seq,
	input  logic adv,
	input  logic pl_we,
	input  eth_tx_pkg::paddr_t pl_addr,
	input  eth_tx_pkg::byte_t pl_data,
	output logic busy,
	output eth_tx_pkg::byte_t data,
	output logic data_valid,
	output logic data_enable,
	tx_cfg_if.builder cfg
);
	import eth_tx_pkg::*;

	byte_t ram [payload_max];
	logic [8*header_bytes-1:0] hdr; // dst, src, type, copy, seq
	plen_t len_q;
	logic [6:0] pos;       // byte index within frame
	logic [6:0] pos_nx;
	logic [6:0] pay_end;   // first index past the payload
	logic [6:0] frame_len; // padded length
	logic last;
	logic pend;            // a byte is presented this strobe
	logic [4:0] tail_cnt;
	build_state_t state, state_nx;
	byte_t byte_nx;

	always_ff @(posedge clk125MHz) begin
		if (pl_we) ram[pl_addr] <= pl_data;
	end

	// header and length frozen for the whole copy
	always_ff @(posedge clk125MHz) begin
		if (start) begin
			hdr   <= {cfg.dst_mac, cfg.src_mac, ethertype, 5'd0, copy_idx, seq};
			len_q <= (cfg.length > plen_t'(payload_max)) ? plen_t'(payload_max) : cfg.length;
		end
	end

	assign pay_end   = 7'(header_bytes) + len_q;
	assign frame_len = (pay_end < 7'(min_frame_bytes)) ? 7'(min_frame_bytes) : pay_end;
	assign last      = (pos == frame_len - 7'd1);
	assign pos_nx    = pos + 7'd1;

	// ==============================
	// byte select and next state
	// ==============================
	always_comb begin
		case (state)
			b_header:  byte_nx = hdr[8*(header_bytes-1-pos[3:0]) +: 8]; // msb first
			b_payload: byte_nx = ram[paddr_t'(pos - 7'(header_bytes))];
			default:   byte_nx = 8'h00; // zero pad
		endcase
		if (last)
			state_nx = b_idle;
		else if (pos_nx < 7'(header_bytes))
			state_nx = b_header;
		else if (pos_nx < pay_end)
			state_nx = b_payload;
		else
			state_nx = b_pad;
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			state       <= b_idle;
			pos         <= '0;
			pend        <= 1'b0;
			data_enable <= 1'b0;
			tail_cnt    <= '0;
		end else if (start) begin
			state <= b_header; // first byte on next adv
			pos   <= '0;
		end else if (adv) begin
			if (state == b_idle) begin
				pend        <= 1'b0;
				data_enable <= 1'b0; // falls one strobe after last byte
				if (tail_cnt != '0) tail_cnt <= tail_cnt - 1'b1;
			end else begin
				pend        <= 1'b1;
				data_enable <= 1'b1;
				pos         <= pos_nx;
				state       <= state_nx;
				if (last) tail_cnt <= 5'(tail_strobes);
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (adv && state != b_idle) data <= byte_nx;
	end

	assign data_valid = pend & adv;
	// held until crc and preamble have drained
	assign busy = start | (state != b_idle) | (tail_cnt != '0);

endmodule

/* design/add_crc32.sv */
`timescale 1ns/10ps

module add_crc32 (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic adv,
	input  eth_tx_pkg::byte_t data_in,
	input  logic data_valid_in,
	input  logic data_enable_in,
	output eth_tx_pkg::byte_t data_out,
	output logic data_valid_out,
	output logic data_enable_out
);
	import eth_tx_pkg::*;

	logic [31:0] crc;
	logic [31:0] crc_nx;
	logic [23:0] fcs_sr;   // remaining fcs bytes
	logic [1:0] fcs_left;
	logic en_prev;         // input enable at last strobe
	logic pend;

	// reflected crc, lsb of each byte first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r[0] ^ d[i]) ? ((r >> 1) ^ crc_poly_refl) : (r >> 1);
		end
		return r;
	endfunction

	assign crc_nx = crc_byte(en_prev ? crc : 32'hFFFF_FFFF, data_in); // reseed per frame

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			en_prev         <= 1'b0;
			pend            <= 1'b0;
			data_enable_out <= 1'b0;
			fcs_left        <= '0;
		end else if (adv) begin
			en_prev <= data_enable_in;
			if (data_enable_in) begin
				pend            <= data_valid_in;
				data_enable_out <= 1'b1;
			end else if (en_prev || fcs_left != '0) begin
				pend            <= 1'b1; // fcs strobes
				data_enable_out <= 1'b1;
				fcs_left        <= en_prev ? 2'd3 : fcs_left - 2'd1;
			end else begin
				pend            <= 1'b0;
				data_enable_out <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (adv) begin
			if (data_enable_in) begin
				data_out <= data_in; // one strobe delay
				if (data_valid_in) crc <= crc_nx;
			end else if (en_prev) begin
				data_out <= ~crc[7:0]; // low byte first
				fcs_sr   <= ~crc[31:8];
			end else begin
				data_out <= fcs_sr[7:0];
				fcs_sr   <= fcs_sr >> 8;
			end
		end
	end

	assign data_valid_out = pend & adv;

endmodule

/* design/add_preamble.sv */
`timescale 1ns/10ps

module add_preamble (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic adv,
	input  eth_tx_pkg::byte_t data_in,
	input  logic data_valid_in,
	input  logic data_enable_in,
	output eth_tx_pkg::byte_t data_out,
	output logic data_valid_out,
	output logic data_enable_out,
	output logic frame_done
);
	import eth_tx_pkg::*;

	byte_t dl [8];     // eight strobe delay line
	logic [7:0] dl_v;
	logic [7:0] dl_e;
	byte_t sel_data;
	logic sel_valid;
	logic sel_en;

	always_comb begin
		if (dl_e[7]) begin
			sel_data  = dl[7]; // delayed frame byte
			sel_valid = dl_v[7];
			sel_en    = 1'b1;
		end else if (data_enable_in || dl_e[6:0] != '0) begin
			sel_data  = dl_e[6] ? sfd_byte : preamble_byte; // sfd just before data
			sel_valid = 1'b1;
			sel_en    = 1'b1;
		end else begin
			sel_data  = 8'h00;
			sel_valid = 1'b0;
			sel_en    = 1'b0;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (adv) begin
			dl[0] <= data_in;
			for (int i = 1; i < 8; i++) dl[i] <= dl[i-1];
			data_out <= sel_data;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			dl_v            <= '0;
			dl_e            <= '0;
			data_valid_out  <= 1'b0;
			data_enable_out <= 1'b0;
			frame_done      <= 1'b0;
		end else begin
			data_valid_out <= 1'b0; // one cycle per strobe
			frame_done     <= 1'b0;
			if (adv) begin
				dl_v            <= {dl_v[6:0], data_valid_in};
				dl_e            <= {dl_e[6:0], data_enable_in};
				data_valid_out  <= sel_valid;
				data_enable_out <= sel_en;
				frame_done      <= data_enable_out & ~sel_en; // with enable fall
			end
		end
	end

endmodule

/* design/eth_tx_top.sv */
`timescale 1ns/10ps

module eth_tx_top (
	input  logic clk125MHz,
	input  logic rst_n,
	input  logic [eth_tx_pkg::axi_addr_w-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [eth_tx_pkg::axi_data_w-1:0] wdata,
	input  logic [eth_tx_pkg::axi_data_w/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic [eth_tx_pkg::axi_addr_w-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic rvalid,
	input  logic rready,
	output logic [eth_tx_pkg::axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output eth_tx_pkg::byte_t gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_valid
);
	import eth_tx_pkg::*;

	logic start, adv, busy, frame_done;
	copies_t copy_idx;
	byte_t seq;
	logic pl_we;
	paddr_t pl_addr;
	byte_t pl_data;
	byte_t raw_data, crc_data; // builder out, crc out
	logic raw_valid, raw_enable;
	logic crc_valid, crc_enable;

	tx_cfg_if cfg();

	// ==============================
	// control side
	// ==============================
	tx_csr_axil i_csr (
		.clk125MHz(clk125MHz), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.frame_done(frame_done),
		.pl_we(pl_we), .pl_addr(pl_addr), .pl_data(pl_data),
		.cfg(cfg.csr)
	);

	tx_scheduler i_sched (
		.clk125MHz(clk125MHz), .rst_n(rst_n), .busy(busy),
		.start(start), .copy_idx(copy_idx), .seq(seq), .adv(adv),
		.cfg(cfg.sched)
	);

	// ==============================
	// byte stream
	// ==============================
	frame_builder i_builder (
		.clk125MHz(clk125MHz), .rst_n(rst_n),
		.start(start), .copy_idx(copy_idx), .seq(seq), .adv(adv),
		.pl_we(pl_we), .pl_addr(pl_addr), .pl_data(pl_data),
		.busy(busy), .data(raw_data), .data_valid(raw_valid), .data_enable(raw_enable),
		.cfg(cfg.builder)
	);

	add_crc32 i_crc (
		.clk125MHz(clk125MHz), .rst_n(rst_n), .adv(adv),
		.data_in(raw_data), .data_valid_in(raw_valid), .data_enable_in(raw_enable),
		.data_out(crc_data), .data_valid_out(crc_valid), .data_enable_out(crc_enable)
	);

	add_preamble i_pre (
		.clk125MHz(clk125MHz), .rst_n(rst_n), .adv(adv),
		.data_in(crc_data), .data_valid_in(crc_valid), .data_enable_in(crc_enable),
		.data_out(gmii_txd), .data_valid_out(gmii_tx_valid), .data_enable_out(gmii_tx_en),
		.frame_done(frame_done) // back to status count
	);

endmodule

/* verif/tb_eth_tx.sv */
`timescale 1ns/10ps

module tb_eth_tx;
	import eth_tx_pkg::*;

	localparam int max_frames = 16;
	// summed worst case is about 28k cycles, mostly the 10 Mb frame, so twice that
	localparam int max_cycles = 60000;
	localparam logic [47:0] dst_mac = 48'h02_1A_2B_3C_4D_5E;
	localparam logic [47:0] src_mac = 48'h02_A1_B2_C3_D4_E5;

	logic clk125MHz;
	logic rst_n;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	byte_t gmii_txd;
	logic gmii_tx_en;
	logic gmii_tx_valid;

	int cycle;
	int errors;
	int test_err;
	int tests_pass;
	int tests_fail;
	int bursts;           // bursts started since reset, sets expected seq
	int frames_exp;       // frames the link should have sent so far
	integer seed = 7;
	byte_t payload [64];  // copy of the payload ram

	// monitor record, one slot per frame
	byte_t mon_data [max_frames][128];
	int mon_len [max_frames];    // valid bytes seen
	int mon_start [max_frames];  // cycle of gmii_tx_en rise
	int mon_stop [max_frames];   // cycle of gmii_tx_en fall
	int mon_en_cyc [max_frames];
	int mon_min_sp [max_frames]; // valid strobe spacing
	int mon_max_sp [max_frames];
	int mon_cnt;
	int last_valid;
	int sp;
	logic en_q;

	byte_t exp_bytes [128]; // model output
	int exp_len;

	eth_tx_top dut (
		.clk125MHz(clk125MHz), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_valid(gmii_tx_valid)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz; // 8 ns period
	end

	// watchdog
	always @(posedge clk125MHz) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("timeout: run went past %0d cycles, a frame or response never came", max_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ==============================
	// gmii monitor
	// ==============================
	always @(negedge clk125MHz) begin
		if (!rst_n) begin
			en_q = 1'b0;
		end else begin
			if (gmii_tx_en && mon_cnt < max_frames) begin
				if (!en_q) begin // new frame
					mon_start[mon_cnt]  = cycle;
					mon_len[mon_cnt]    = 0;
					mon_en_cyc[mon_cnt] = 0;
					mon_min_sp[mon_cnt] = 1 << 30;
					mon_max_sp[mon_cnt] = 0;
					last_valid = -1;
				end
				mon_en_cyc[mon_cnt] = mon_en_cyc[mon_cnt] + 1;
				if (gmii_tx_valid) begin
					if (mon_len[mon_cnt] < 128)
						mon_data[mon_cnt][mon_len[mon_cnt]] = gmii_txd;
					mon_len[mon_cnt] = mon_len[mon_cnt] + 1;
					if (last_valid >= 0) begin
						sp = cycle - last_valid;
						if (sp < mon_min_sp[mon_cnt]) mon_min_sp[mon_cnt] = sp;
						if (sp > mon_max_sp[mon_cnt]) mon_max_sp[mon_cnt] = sp;
					end
					last_valid = cycle;
				end
			end
			if (!gmii_tx_en && en_q && mon_cnt < max_frames) begin
				mon_stop[mon_cnt] = cycle; // frame closed
				mon_cnt = mon_cnt + 1;
			end
			en_q = gmii_tx_en;
		end
	end

	// ==============================
	// checks and bus driver
	// ==============================
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic confirm(input logic cond, input string msg);
		assert (cond) else begin
			$display("%0t ns: %s", $time, msg);
			errors++;
			test_err++;
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] val, input int hold);
		@(posedge clk125MHz);
		awaddr  <= addr;
		wdata   <= val;
		wstrb   <= 4'hF;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk125MHz);
		while (!awready) @(posedge clk125MHz);
		check_value("wready", wready, 1'b1); // rises with awready
		awvalid <= 1'b0; // aw and w accepted together
		wvalid  <= 1'b0;
		while (!bvalid) @(posedge clk125MHz);
		repeat (hold) begin
			@(posedge clk125MHz);
			confirm(bvalid, "bvalid dropped while bready was still low");
		end
		check_value("bresp", bresp, 2'b00);
		bready <= 1'b1;
		@(posedge clk125MHz);
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] val);
		@(posedge clk125MHz);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk125MHz);
		while (!arready) @(posedge clk125MHz);
		arvalid <= 1'b0;
		while (!rvalid) @(posedge clk125MHz);
		repeat (hold) begin
			@(posedge clk125MHz);
			confirm(rvalid, "rvalid dropped while rready was still low");
		end
		val = rdata;
		check_value("rresp", rresp, 2'b00);
		rready <= 1'b1;
		@(posedge clk125MHz);
		rready <= 1'b0;
	endtask

	task automatic roundtrip(input logic [7:0] addr, input logic [31:0] val,
		input logic [31:0] mask, input int hold);
		logic [31:0] rd;
		write_reg(addr, val, hold);
		read_reg(addr, hold, rd);
		check_value($sformatf("reg 0x%02h", addr), rd, val & mask); // field width only
	endtask

	task automatic load_payload(input int len);
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			payload[i] = r[7:0];
			write_reg(8'h40 + 8'(i), {24'h0, payload[i]}, 0); // one byte per address
		end
	endtask

	// link stays off while the fields change
	task automatic configure(input int copies, input int gap, input int len, input int ivl);
		write_reg(reg_ctrl, 32'h0, 0);
		write_reg(reg_interval, ivl, 0);
		write_reg(reg_copies, copies, 0);
		write_reg(reg_gap, gap, 0);
		write_reg(reg_length, len, 0);
		write_reg(reg_dst_lo, dst_mac[31:0], 0);
		write_reg(reg_dst_hi, {16'h0, dst_mac[47:32]}, 0);
		write_reg(reg_src_lo, src_mac[31:0], 0);
		write_reg(reg_src_hi, {16'h0, src_mac[47:32]}, 0);
	endtask

	task automatic enable_link(input logic [1:0] spd);
		write_reg(reg_ctrl, {29'd0, spd, 1'b1}, 0);
	endtask

	task automatic wait_frames(input int n);
		while (mon_cnt < n) @(posedge clk125MHz); // watchdog ends a hang
	endtask

	// ==============================
	// reference frame model
	// ==============================
	function automatic void build_expected(input int cidx, input int sq, input int len);
		int n;
		logic fb;
		logic [31:0] c;
		logic [31:0] fcs;
		n = 8; // body starts after preamble and sfd
		for (int i = 5; i >= 0; i--) begin
			exp_bytes[n] = dst_mac[8*i +: 8]; // msb first
			n++;
		end
		for (int i = 5; i >= 0; i--) begin
			exp_bytes[n] = src_mac[8*i +: 8];
			n++;
		end
		exp_bytes[n] = 8'h88;
		exp_bytes[n+1] = 8'hB5;
		exp_bytes[n+2] = 8'(cidx);
		exp_bytes[n+3] = 8'(sq);
		n = n + 4;
		for (int i = 0; i < len; i++) begin
			exp_bytes[n] = payload[i];
			n++;
		end
		while (n < 8 + 60) begin
			exp_bytes[n] = 8'h00; // pad
			n++;
		end
		// plain msb-first crc, bits of each byte fed lsb first
		c = 32'hFFFF_FFFF;
		for (int k = 8; k < n; k++) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[31] ^ exp_bytes[k][b];
				c = c << 1;
				if (fb) c = c ^ 32'h04C11DB7;
			end
		end
		for (int b = 0; b < 32; b++) fcs[b] = ~c[31-b];
		for (int i = 0; i < 4; i++) begin
			exp_bytes[n] = fcs[8*i +: 8]; // low byte on the wire first
			n++;
		end
		for (int i = 0; i < 7; i++) exp_bytes[i] = 8'h55;
		exp_bytes[7] = 8'hD5;
		exp_len = n;
	endfunction

	task automatic compare_frame(input int idx, input int cidx, input int sq, input int len);
		build_expected(cidx, sq, len);
		confirm(idx < mon_cnt, "expected frame was never captured");
		check_value($sformatf("frame %0d byte count", idx), mon_len[idx], exp_len);
		for (int k = 0; k < exp_len && k < mon_len[idx]; k++)
			check_value($sformatf("gmii_txd frame %0d byte %0d", idx, k),
				mon_data[idx][k], exp_bytes[k]);
	endtask

	task automatic finish_test(input string name);
		if (test_err == 0) begin
			tests_pass++;
			$display("pass  %s", name);
		end else begin
			tests_fail++;
			$display("fail  %s, %0d errors", name, test_err);
		end
		test_err = 0;
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic register_access();
		logic [31:0] rd;
		logic [7:0] unmapped [6] = '{8'h28, 8'h3C, 8'h40, 8'h7C, 8'h80, 8'hFC};
		check_value("bvalid", bvalid, 1'b0); // reset state
		check_value("rvalid", rvalid, 1'b0);
		check_value("gmii_tx_en", gmii_tx_en, 1'b0);
		roundtrip(reg_ctrl, 32'h0000_0004, 32'h7, 0); // speed 10, link off
		roundtrip(reg_interval, 32'hA55A_C33C, 32'h00FF_FFFF, 3);
		roundtrip(reg_copies, 32'hFFFF_FFF5, 32'h7, 0);
		roundtrip(reg_gap, 32'h1234_BEEF, 32'hFFFF, 5);
		roundtrip(reg_length, 32'hFFFF_FFAA, 32'h7F, 0);
		roundtrip(reg_dst_lo, 32'hDEAD_BEEF, 32'hFFFF_FFFF, 2);
		roundtrip(reg_dst_hi, 32'h5555_CAFE, 32'hFFFF, 0);
		roundtrip(reg_src_lo, 32'h0BAD_F00D, 32'hFFFF_FFFF, 4);
		roundtrip(reg_src_hi, 32'hAAAA_1357, 32'hFFFF, 0);
		write_reg(reg_status, 32'hFFFF_FFFF, 0); // read only
		read_reg(reg_status, 0, rd);
		check_value("reg_status", rd, 32'h0);
		for (int i = 0; i < 6; i++) begin
			read_reg(unmapped[i], (i % 2) * 4, rd);
			check_value($sformatf("unmapped 0x%02h", unmapped[i]), rd, 32'h0);
		end
		finish_test("register access");
	endtask

	task automatic single_gigabit_frame();
		int base;
		logic [31:0] rd;
		load_payload(20);
		configure(1, 0, 20, 1000);
		base = mon_cnt;
		enable_link(spd_1000);
		wait_frames(base + 1);
		write_reg(reg_ctrl, 32'h0, 0);
		bursts++;
		frames_exp++;
		compare_frame(base, 1, bursts, 20);
		check_value("frame length", mon_len[base], 8 + 60 + 4);
		check_value("gmii_tx_en cycles", mon_en_cyc[base], 8 + 60 + 4); // no idle strobes
		read_reg(reg_status, 0, rd);
		check_value("reg_status", rd, 1);
		finish_test("single gigabit frame");
	endtask

	task automatic redundancy();
		int base;
		configure(3, 40, 20, 2000);
		base = mon_cnt;
		enable_link(spd_1000);
		wait_frames(base + 3);
		write_reg(reg_ctrl, 32'h0, 0);
		bursts++;
		frames_exp += 3;
		for (int k = 0; k < 3; k++) begin
			compare_frame(base + k, k + 1, bursts, 20);
			check_value("copy index", mon_data[base+k][22], k + 1);
			check_value("seq", mon_data[base+k][23], 8'(bursts)); // same burst
		end
		for (int k = 1; k < 3; k++)
			confirm(mon_start[base+k] - mon_stop[base+k-1] >= 40,
				$sformatf("copy %0d followed the previous one after less than the gap", k + 1));
		finish_test("redundancy");
	endtask

	task automatic burst_interval();
		int base;
		configure(1, 0, 20, 300);
		base = mon_cnt;
		enable_link(spd_1000);
		wait_frames(base + 2);
		write_reg(reg_ctrl, 32'h0, 0); // before the third expiry
		bursts += 2;
		frames_exp += 2;
		compare_frame(base, 1, bursts - 1, 20);
		compare_frame(base + 1, 1, bursts, 20);
		check_value("seq step", 8'(mon_data[base+1][23] - mon_data[base][23]), 1);
		confirm(mon_start[base+1] - mon_start[base] >= 300,
			"two bursts started closer than the interval");
		repeat (1000) @(posedge clk125MHz);
		check_value("frames after disable", mon_cnt, base + 2);
		finish_test("burst interval");
	endtask

	task automatic speed_pacing();
		int base;
		int step;
		int ivl;
		logic [1:0] spd;
		for (int s = 0; s < 2; s++) begin
			spd  = (s == 0) ? spd_100 : spd_10;
			step = (s == 0) ? 10 : 100;   // cycles per byte strobe
			ivl  = (s == 0) ? 2000 : 10000; // longer than one slow frame
			configure(1, 0, 20, ivl);
			base = mon_cnt;
			enable_link(spd);
			wait_frames(base + 1);
			write_reg(reg_ctrl, 32'h0, 0);
			bursts++;
			frames_exp++;
			compare_frame(base, 1, bursts, 20);
			check_value($sformatf("gmii_tx_valid min spacing, %0d step", step),
				mon_min_sp[base], step);
			check_value($sformatf("gmii_tx_valid max spacing, %0d step", step),
				mon_max_sp[base], step);
		end
		finish_test("speed pacing");
	endtask

	task automatic full_payload();
		int base;
		logic [31:0] rd;
		load_payload(64);
		configure(1, 0, 64, 1000);
		base = mon_cnt;
		enable_link(spd_1000);
		wait_frames(base + 1);
		write_reg(reg_ctrl, 32'h0, 0);
		bursts++;
		frames_exp++;
		compare_frame(base, 1, bursts, 64);
		check_value("frame length", mon_len[base], 8 + 80 + 4); // no pad
		read_reg(reg_status, 0, rd);
		check_value("reg_status", rd, frames_exp);
		finish_test("full payload");
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		cycle   = 0;
		errors  = 0;
		test_err = 0;
		tests_pass = 0;
		tests_fail = 0;
		bursts  = 0;
		frames_exp = 0;
		mon_cnt = 0;
		repeat (10) @(posedge clk125MHz);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk125MHz);
		register_access();
		single_gigabit_frame();
		redundancy();
		burst_interval();
		speed_pacing();
		full_payload();
		$display("%0d tests passed, %0d tests failed, %0d errors", tests_pass, tests_fail, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* filelist.f */
design/eth_tx_pkg.sv
design/tx_cfg_if.sv
design/tx_csr_axil.sv
design/tx_scheduler.sv
design/frame_builder.sv
design/add_crc32.sv
design/add_preamble.sv
design/eth_tx_top.sv
verif/tb_eth_tx.sv

/* Bender.yml */
package:
  name: eth_tx

sources:
  - files:
      - design/eth_tx_pkg.sv
      - design/tx_cfg_if.sv
      - design/tx_csr_axil.sv
      - design/tx_scheduler.sv
      - design/frame_builder.sv
      - design/add_crc32.sv
      - design/add_preamble.sv
      - design/eth_tx_top.sv
  - target: simulation
    files:
      - verif/tb_eth_tx.sv
